// File: hw/io_port_pkg.sv
/*
 * I/O port package
 * Address and data widths, port count and the base addresses of the
 * read and write port blocks shared by the port check stage
 */

package io_port_pkg;

    // ----------------------------------------------------------
    // Processor side widths
    // ----------------------------------------------------------

    // Word address presented by the processor
    localparam int ADDR_WIDTH = 10;

    // Data word carried by every port
    localparam int WORD_WIDTH = 16;

    // ----------------------------------------------------------
    // Port blocks
    // ----------------------------------------------------------

    // Same count on the read side and on the write side
    localparam int PORT_COUNT = 4;

    // Bits needed to index one port within its block
    localparam int PORT_ADDR_WIDTH = 2;

    // Read ports sit at 0x010 through 0x013
    localparam logic [ADDR_WIDTH-1:0] RD_PORT_BASE_ADDR = 10'h010;

    // Write ports sit at 0x020 through 0x023
    localparam logic [ADDR_WIDTH-1:0] WR_PORT_BASE_ADDR = 10'h020;

    // ----------------------------------------------------------
    // Configuration word
    // ----------------------------------------------------------

    // Low half holds read enables and high half holds write enables
    localparam int CFG_WIDTH = 2 * PORT_COUNT;

endpackage

// File: hw/io_check.sv
/*
 * I/O address check
 * Decodes one address against a port block, selects that port's full
 * flag and substitutes the side's ready state for memory addresses
 */

`timescale 1ns/1ns

module io_check #(
    // Flag value that means ready (1 for reads, 0 for writes)
    parameter bit ready_state = 1'b1,
    parameter logic [io_port_pkg::ADDR_WIDTH-1:0] port_base_addr =
        io_port_pkg::RD_PORT_BASE_ADDR
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   enable,
    input  logic [io_port_pkg::ADDR_WIDTH-1:0]     addr,
    input  logic [io_port_pkg::PORT_COUNT-1:0]     port_full,
    output logic                                   port_full_masked,
    output logic                                   addr_is_io,
    output logic [io_port_pkg::PORT_ADDR_WIDTH-1:0] port_index
);

    // ----------------------------------------------------------
    // Stage 1 range decode and flag select
    // ----------------------------------------------------------

    logic [io_port_pkg::ADDR_WIDTH-1:0]      addr_offset;
    logic [io_port_pkg::PORT_ADDR_WIDTH-1:0] port_index_next;
    logic                                    addr_hit;
    logic                                    full_selected;
    logic                                    full_selected_q;

    // Addresses below the base wrap to a large offset and miss
    assign addr_offset = addr - port_base_addr;

    // Hit only for an enabled request inside the block
    assign addr_hit = enable && (addr_offset < io_port_pkg::PORT_COUNT);

    // Low offset bits index the port
    assign port_index_next = addr_offset[io_port_pkg::PORT_ADDR_WIDTH-1:0];

    // Flag of the addressed port, meaningful only on a hit
    assign full_selected = port_full[port_index_next];

    // Hit is control state and clears on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            addr_is_io <= 1'b0;
        end else begin
            addr_is_io <= addr_hit;
        end
    end

    // Flag and index only matter while addr_is_io is high
    always_ff @(posedge clock) begin
        full_selected_q <= full_selected;
        port_index      <= port_index_next;
    end

    // ----------------------------------------------------------
    // Stage 2 masking
    // ----------------------------------------------------------

    // Memory is always ready so a miss reports the ready state
    assign port_full_masked = addr_is_io ? full_selected_q : ready_state;

    // A reported hit names the real port that the sampled address pointed at
    assert property (@(posedge clock) disable iff (reset)
        addr_is_io |-> $past(enable) &&
            (int'($past(addr)) == int'(port_base_addr) + int'(port_index)))
    else $error("io_check: I/O hit with port_index %0d off its address", port_index);

endmodule

// File: hw/io_read.sv
/*
 * Read side of the I/O port stage
 * Checks the read address, reports readiness one cycle later and pops
 * the selected read port while returning its data word
 */

`timescale 1ns/1ns

module io_read (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   rd_enable,
    input  logic [io_port_pkg::ADDR_WIDTH-1:0]     rd_addr,
    input  logic [io_port_pkg::PORT_COUNT-1:0]     rd_port_full,
    input  logic [io_port_pkg::PORT_COUNT-1:0][io_port_pkg::WORD_WIDTH-1:0] rd_port_data,
    input  logic [io_port_pkg::PORT_COUNT-1:0]     rd_port_enable,
    output logic                                   rd_is_io,
    output logic                                   rd_ready,
    output logic [io_port_pkg::WORD_WIDTH-1:0]     rd_data,
    output logic [io_port_pkg::PORT_COUNT-1:0]     rd_port_pop
);

    logic [io_port_pkg::PORT_COUNT-1:0]      port_full_gated;
    logic [io_port_pkg::PORT_ADDR_WIDTH-1:0] port_index;
    logic [io_port_pkg::PORT_COUNT-1:0][io_port_pkg::WORD_WIDTH-1:0] port_data_q;

    // ----------------------------------------------------------
    // Port gating and address check
    // ----------------------------------------------------------

    // A disabled read port never shows data available
    assign port_full_gated = rd_port_full & rd_port_enable;

    io_check #(
        .ready_state    (1'b1),
        .port_base_addr (io_port_pkg::RD_PORT_BASE_ADDR)
    ) rd_check (
        .clock            (clock),
        .reset            (reset),
        .enable           (rd_enable),
        .addr             (rd_addr),
        .port_full        (port_full_gated),
        .port_full_masked (rd_ready),
        .addr_is_io       (rd_is_io),
        .port_index       (port_index)
    );

    // ----------------------------------------------------------
    // Data path
    // ----------------------------------------------------------

    // Capture every port word alongside stage 1 of the check
    always_ff @(posedge clock) begin
        port_data_q <= rd_port_data;
    end

    // Word of the addressed port
    // valid only when the access is a ready I/O read
    assign rd_data = port_data_q[port_index];

    // ----------------------------------------------------------
    // Pop strobe
    // ----------------------------------------------------------

    // One-hot pop on the addressed port when it is I/O and ready
    always_comb begin
        for (int i = 0; i < io_port_pkg::PORT_COUNT; i++) begin
            rd_port_pop[i] = rd_is_io && rd_ready &&
                (port_index == io_port_pkg::PORT_ADDR_WIDTH'(i));
        end
    end

    // At most one read port is popped per cycle
    assert property (@(posedge clock) disable iff (reset)
        $onehot0(rd_port_pop))
    else $error("io_read: rd_port_pop %b is not one-hot", rd_port_pop);

    // A pop only goes to a port that was enabled when it was sampled
    assert property (@(posedge clock) disable iff (reset)
        |rd_port_pop |-> |(rd_port_pop & $past(rd_port_enable)))
    else $error("io_read: pop issued to a disabled port");

endmodule

// File: hw/io_write.sv
/*
 * Write side of the I/O port stage
 * Checks the write address, reports readiness one cycle later and
 * pushes the registered write word into the selected write port
 */

`timescale 1ns/1ns

module io_write (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   wr_enable,
    input  logic [io_port_pkg::ADDR_WIDTH-1:0]     wr_addr,
    input  logic [io_port_pkg::WORD_WIDTH-1:0]     wr_data,
    input  logic [io_port_pkg::PORT_COUNT-1:0]     wr_port_full,
    input  logic [io_port_pkg::PORT_COUNT-1:0]     wr_port_enable,
    output logic                                   wr_is_io,
    output logic                                   wr_ready,
    output logic [io_port_pkg::PORT_COUNT-1:0]     wr_port_push,
    output logic [io_port_pkg::WORD_WIDTH-1:0]     wr_port_data
);

    logic [io_port_pkg::PORT_COUNT-1:0]      port_full_gated;
    logic [io_port_pkg::PORT_ADDR_WIDTH-1:0] port_index;
    logic                                    port_full_masked;

    // ----------------------------------------------------------
    // Port gating and address check
    // ----------------------------------------------------------

    // A disabled write port always looks full
    assign port_full_gated = wr_port_full | ~wr_port_enable;

    io_check #(
        .ready_state    (1'b0),
        .port_base_addr (io_port_pkg::WR_PORT_BASE_ADDR)
    ) wr_check (
        .clock            (clock),
        .reset            (reset),
        .enable           (wr_enable),
        .addr             (wr_addr),
        .port_full        (port_full_gated),
        .port_full_masked (port_full_masked),
        .addr_is_io       (wr_is_io),
        .port_index       (port_index)
    );

    // Ready means the selected port has space, or memory
    assign wr_ready = ~port_full_masked;

    // ----------------------------------------------------------
    // Data path
    // ----------------------------------------------------------

    // Write word lines up with the registered check result
    always_ff @(posedge clock) begin
        wr_port_data <= wr_data;
    end

    // ----------------------------------------------------------
    // Push strobe
    // ----------------------------------------------------------

    // One-hot push on the addressed port when it has space
    always_comb begin
        for (int i = 0; i < io_port_pkg::PORT_COUNT; i++) begin
            wr_port_push[i] = wr_is_io && wr_ready &&
                (port_index == io_port_pkg::PORT_ADDR_WIDTH'(i));
        end
    end

    // Push follows a write that was enabled and had space one cycle back
    assert property (@(posedge clock) disable iff (reset)
        |wr_port_push |-> wr_ready && $past(wr_enable))
    else $error("io_write: push without a ready write request");

    // Pushed port was neither full nor disabled when sampled
    assert property (@(posedge clock) disable iff (reset)
        |wr_port_push |-> ~|(wr_port_push & $past(port_full_gated)))
    else $error("io_write: push into a full or disabled port");

endmodule

// File: hw/io_port_config.sv
/*
 * Port enable register block
 * Holds the read and write port enable masks, loaded together from
 * one configuration word
 */

`timescale 1ns/1ns

module io_port_config (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               cfg_write,
    input  logic [io_port_pkg::CFG_WIDTH-1:0]  cfg_data,
    output logic [io_port_pkg::PORT_COUNT-1:0] rd_port_enable,
    output logic [io_port_pkg::PORT_COUNT-1:0] wr_port_enable
);

    // ----------------------------------------------------------
    // Field split
    // ----------------------------------------------------------

    logic [io_port_pkg::PORT_COUNT-1:0] rd_enable_next;
    logic [io_port_pkg::PORT_COUNT-1:0] wr_enable_next;

    // Low half of the word enables read ports
    assign rd_enable_next = cfg_data[io_port_pkg::PORT_COUNT-1:0];

    // High half enables write ports
    assign wr_enable_next =
        cfg_data[io_port_pkg::CFG_WIDTH-1:io_port_pkg::PORT_COUNT];

    // ----------------------------------------------------------
    // Mask registers
    // ----------------------------------------------------------

    // All ports come out of reset enabled
    // a write updates both masks at once
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_port_enable <= '1;
            wr_port_enable <= '1;
        end else if (cfg_write) begin
            rd_port_enable <= rd_enable_next;
            wr_port_enable <= wr_enable_next;
        end
    end

    // Masks only move on a configuration write
    assert property (@(posedge clock) disable iff (reset)
        !$past(cfg_write) && !$past(reset) |->
            $stable(rd_port_enable) && $stable(wr_port_enable))
    else $error("io_port_config: enable mask changed without cfg_write");

endmodule

// File: hw/io_subsystem.sv
/*
 * I/O port check subsystem
 * Joins the port enable registers with the read and write sides
 */

`timescale 1ns/1ns

module io_subsystem (
    input  logic                                   clock,
    input  logic                                   reset,
    // Read request and read ports
    input  logic                                   rd_enable,
    input  logic [io_port_pkg::ADDR_WIDTH-1:0]     rd_addr,
    input  logic [io_port_pkg::PORT_COUNT-1:0]     rd_port_full,
    input  logic [io_port_pkg::PORT_COUNT-1:0][io_port_pkg::WORD_WIDTH-1:0] rd_port_data,
    output logic                                   rd_is_io,
    output logic                                   rd_ready,
    output logic [io_port_pkg::WORD_WIDTH-1:0]     rd_data,
    output logic [io_port_pkg::PORT_COUNT-1:0]     rd_port_pop,
    // Write request and write ports
    input  logic                                   wr_enable,
    input  logic [io_port_pkg::ADDR_WIDTH-1:0]     wr_addr,
    input  logic [io_port_pkg::WORD_WIDTH-1:0]     wr_data,
    input  logic [io_port_pkg::PORT_COUNT-1:0]     wr_port_full,
    output logic                                   wr_is_io,
    output logic                                   wr_ready,
    output logic [io_port_pkg::PORT_COUNT-1:0]     wr_port_push,
    output logic [io_port_pkg::WORD_WIDTH-1:0]     wr_port_data,
    // Port enable configuration
    input  logic                                   cfg_write,
    input  logic [io_port_pkg::CFG_WIDTH-1:0]      cfg_data
);

    // Enable masks from the register block
    logic [io_port_pkg::PORT_COUNT-1:0] rd_port_enable;
    logic [io_port_pkg::PORT_COUNT-1:0] wr_port_enable;

    // ----------------------------------------------------------
    // Configuration
    // ----------------------------------------------------------

    io_port_config config0 (
        .clock          (clock),
        .reset          (reset),
        .cfg_write      (cfg_write),
        .cfg_data       (cfg_data),
        .rd_port_enable (rd_port_enable),
        .wr_port_enable (wr_port_enable)
    );

    // ----------------------------------------------------------
    // Read and write sides
    // ----------------------------------------------------------

    io_read read0 (
        .clock          (clock),
        .reset          (reset),
        .rd_enable      (rd_enable),
        .rd_addr        (rd_addr),
        .rd_port_full   (rd_port_full),
        .rd_port_data   (rd_port_data),
        .rd_port_enable (rd_port_enable),
        .rd_is_io       (rd_is_io),
        .rd_ready       (rd_ready),
        .rd_data        (rd_data),
        .rd_port_pop    (rd_port_pop)
    );

    io_write write0 (
        .clock          (clock),
        .reset          (reset),
        .wr_enable      (wr_enable),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_port_full   (wr_port_full),
        .wr_port_enable (wr_port_enable),
        .wr_is_io       (wr_is_io),
        .wr_ready       (wr_ready),
        .wr_port_push   (wr_port_push),
        .wr_port_data   (wr_port_data)
    );

endmodule

// File: sim/tb_clock.sv
/*
 * Testbench clock and reset generator
 * Free running clock with reset held high for the first few cycles
 */

`timescale 1ns/1ns

module tb_clock #(
    parameter int period       = 10,
    parameter int reset_cycles = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Release lines up with a rising edge like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// File: sim/io_subsystem_tb.sv
/*
 * Testbench for the I/O port check subsystem
 * Directed and random tests checked against a reference model of the ready rule
 */

`timescale 1ns/1ns

module io_subsystem_tb;

    // Reset, directed tests and random traffic, in cycles
    localparam int TEST_CYCLES = 230;

    logic clock;
    logic reset;
    // DUT inputs, each updated with a non-blocking assignment on the rising edge
    logic rd_enable, wr_enable, cfg_write;
    logic [io_port_pkg::ADDR_WIDTH-1:0] rd_addr, wr_addr;
    logic [io_port_pkg::PORT_COUNT-1:0] rd_port_full, wr_port_full;
    logic [io_port_pkg::PORT_COUNT-1:0][io_port_pkg::WORD_WIDTH-1:0] rd_port_data;
    logic [io_port_pkg::WORD_WIDTH-1:0] wr_data;
    logic [io_port_pkg::CFG_WIDTH-1:0]  cfg_data;
    // DUT outputs
    logic rd_is_io, rd_ready, wr_is_io, wr_ready;
    logic [io_port_pkg::WORD_WIDTH-1:0] rd_data, wr_port_data;
    logic [io_port_pkg::PORT_COUNT-1:0] rd_port_pop, wr_port_push;
    // Values for the next request, set by the tests
    logic next_rd_enable, next_wr_enable, next_cfg_write;
    logic [io_port_pkg::ADDR_WIDTH-1:0] next_rd_addr, next_wr_addr;
    logic [io_port_pkg::PORT_COUNT-1:0] next_rd_port_full, next_wr_port_full;
    logic [io_port_pkg::PORT_COUNT-1:0][io_port_pkg::WORD_WIDTH-1:0] next_rd_port_data;
    logic [io_port_pkg::WORD_WIDTH-1:0] next_wr_data;
    logic [io_port_pkg::CFG_WIDTH-1:0]  next_cfg_data;
    // Reference model state and expected outputs
    logic [io_port_pkg::PORT_COUNT-1:0] rd_mask, wr_mask, exp_rd_pop, exp_wr_push;
    logic exp_rd_is_io, exp_rd_ready, exp_wr_is_io, exp_wr_ready;
    logic [io_port_pkg::WORD_WIDTH-1:0] exp_rd_data, exp_wr_port_data;
    int error_count, tests_passed, tests_failed;

    tb_clock #(.period(10), .reset_cycles(2)) clock0 (.clock(clock), .reset(reset));

    io_subsystem dut0 (.*);

    // ----------------------------------------------------------
    // Reference model and checks
    // ----------------------------------------------------------

    // Ready rule applied to the inputs being sampled at this edge
    task automatic predict();
        int rd_idx;
        int wr_idx;
        rd_idx = int'(rd_addr) - int'(io_port_pkg::RD_PORT_BASE_ADDR);
        wr_idx = int'(wr_addr) - int'(io_port_pkg::WR_PORT_BASE_ADDR);
        exp_rd_is_io = rd_enable && rd_idx >= 0 && rd_idx < io_port_pkg::PORT_COUNT;
        exp_wr_is_io = wr_enable && wr_idx >= 0 && wr_idx < io_port_pkg::PORT_COUNT;
        // Memory is always ready on both sides
        exp_rd_ready = 1'b1;
        exp_wr_ready = 1'b1;
        exp_rd_pop   = '0;
        exp_wr_push  = '0;
        if (exp_rd_is_io) begin
            // Disabled read port reads as empty
            exp_rd_ready = rd_port_full[rd_idx] && rd_mask[rd_idx];
            exp_rd_pop   = exp_rd_ready ? io_port_pkg::PORT_COUNT'(1 << rd_idx) : '0;
            exp_rd_data  = rd_port_data[rd_idx];
        end
        if (exp_wr_is_io) begin
            // Disabled write port reads as full
            exp_wr_ready = !(wr_port_full[wr_idx] || !wr_mask[wr_idx]);
            exp_wr_push  = exp_wr_ready ? io_port_pkg::PORT_COUNT'(1 << wr_idx) : '0;
        end
        exp_wr_port_data = wr_data;
        // New masks only apply to requests after this edge
        if (cfg_write) begin
            rd_mask = cfg_data[io_port_pkg::PORT_COUNT-1:0];
            wr_mask = cfg_data[io_port_pkg::CFG_WIDTH-1:io_port_pkg::PORT_COUNT];
        end
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_outputs();
        check_value("rd_is_io", 32'(exp_rd_is_io), 32'(rd_is_io));
        check_value("rd_ready", 32'(exp_rd_ready), 32'(rd_ready));
        check_value("rd_port_pop", 32'(exp_rd_pop), 32'(rd_port_pop));
        check_value("wr_is_io", 32'(exp_wr_is_io), 32'(wr_is_io));
        check_value("wr_ready", 32'(exp_wr_ready), 32'(wr_ready));
        check_value("wr_port_push", 32'(exp_wr_push), 32'(wr_port_push));
        // Data words only carry meaning alongside a strobe
        if (exp_rd_pop != '0) check_value("rd_data", 32'(exp_rd_data), 32'(rd_data));
        if (exp_wr_push != '0) check_value("wr_port_data", 32'(exp_wr_port_data),
            32'(wr_port_data));
    endtask

    // One clock: predict what is sampled now, drive the next request, check at mid cycle
    task automatic step();
        @(posedge clock);
        predict();
        rd_enable    <= next_rd_enable;
        rd_addr      <= next_rd_addr;
        rd_port_full <= next_rd_port_full;
        rd_port_data <= next_rd_port_data;
        wr_enable    <= next_wr_enable;
        wr_addr      <= next_wr_addr;
        wr_data      <= next_wr_data;
        wr_port_full <= next_wr_port_full;
        cfg_write    <= next_cfg_write;
        cfg_data     <= next_cfg_data;
        @(negedge clock);
        check_outputs();
    endtask

    task automatic idle_inputs();
        next_rd_enable = 1'b0;
        next_wr_enable = 1'b0;
        next_cfg_write = 1'b0;
    endtask

    task automatic report_test(string name, int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%-16s ok", name);
        end else begin
            tests_failed++;
            $display("%-16s FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Mostly port addresses with a few just outside the block
    function automatic logic [io_port_pkg::ADDR_WIDTH-1:0] pick_addr(
        logic [io_port_pkg::ADDR_WIDTH-1:0] base);
        int choice;
        choice = $urandom_range(0, 3);
        if (choice == 0) return io_port_pkg::ADDR_WIDTH'($urandom);
        if (choice == 1) return base - 1 + io_port_pkg::ADDR_WIDTH'($urandom_range(0, 5));
        return base + io_port_pkg::ADDR_WIDTH'($urandom_range(0, 3));
    endfunction

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------

    task automatic memory_access();
        int errors_before;
        errors_before = error_count;
        idle_inputs();
        next_rd_port_full = '1;
        next_rd_enable = 1'b1;
        next_rd_addr   = 10'h100;
        next_wr_enable = 1'b1;
        next_wr_addr   = 10'h005;
        step();
        // Just past the read block and just below the write block
        next_rd_addr = 10'h014;
        next_wr_addr = 10'h01f;
        step();
        // Port addresses with the strobes low
        idle_inputs();
        next_rd_addr = io_port_pkg::RD_PORT_BASE_ADDR;
        next_wr_addr = io_port_pkg::WR_PORT_BASE_ADDR;
        step();
        step();
        report_test("memory_access", errors_before);
    endtask

    task automatic full_port_reads();
        int errors_before;
        errors_before = error_count;
        next_rd_port_full = '1;
        next_rd_port_data = {16'hd003, 16'hc002, 16'hb001, 16'ha000};
        // Back to back reads of every port
        for (int i = 0; i < io_port_pkg::PORT_COUNT; i++) begin
            next_rd_enable = 1'b1;
            next_rd_addr   = io_port_pkg::RD_PORT_BASE_ADDR + io_port_pkg::ADDR_WIDTH'(i);
            step();
        end
        idle_inputs();
        step();
        report_test("full_port_reads", errors_before);
    endtask

    task automatic empty_port_read();
        int errors_before;
        errors_before = error_count;
        next_rd_port_full = 4'b1011;
        next_rd_enable    = 1'b1;
        next_rd_addr      = io_port_pkg::RD_PORT_BASE_ADDR + 10'd2;
        step();
        idle_inputs();
        step();
        check_value("rd_is_io", 32'(1), 32'(rd_is_io));
        check_value("rd_ready", 32'(0), 32'(rd_ready));
        report_test("empty_port_read", errors_before);
    endtask

    task automatic port_writes();
        int errors_before;
        errors_before = error_count;
        next_wr_port_full = '0;
        for (int i = 0; i < io_port_pkg::PORT_COUNT; i++) begin
            next_wr_enable = 1'b1;
            next_wr_addr   = io_port_pkg::WR_PORT_BASE_ADDR + io_port_pkg::ADDR_WIDTH'(i);
            next_wr_data   = 16'h5a00 + 16'(i);
            step();
        end
        // Full port refuses the write
        next_wr_port_full = '1;
        next_wr_addr      = io_port_pkg::WR_PORT_BASE_ADDR + 10'd1;
        step();
        idle_inputs();
        step();
        check_value("wr_ready", 32'(0), 32'(wr_ready));
        check_value("wr_port_push", 32'(0), 32'(wr_port_push));
        report_test("port_writes", errors_before);
    endtask

    task automatic port_disable();
        int errors_before;
        errors_before = error_count;
        next_rd_port_full = '1;
        next_wr_port_full = '0;
        for (int pass = 0; pass < 2; pass++) begin
            // Read port 1 and write port 2 off, then everything back on
            idle_inputs();
            next_cfg_write = 1'b1;
            next_cfg_data  = (pass == 0) ? 8'hbd : 8'hff;
            step();
            idle_inputs();
            next_rd_enable = 1'b1;
            next_rd_addr   = io_port_pkg::RD_PORT_BASE_ADDR + 10'd1;
            next_wr_enable = 1'b1;
            next_wr_addr   = io_port_pkg::WR_PORT_BASE_ADDR + 10'd2;
            next_wr_data   = 16'h0c0f;
            step();
            idle_inputs();
            step();
            check_value("rd_ready", 32'(pass), 32'(rd_ready));
            check_value("wr_ready", 32'(pass), 32'(wr_ready));
            check_value("rd_port_pop", (pass == 0) ? 32'h0 : 32'h2, 32'(rd_port_pop));
            check_value("wr_port_push", (pass == 0) ? 32'h0 : 32'h4, 32'(wr_port_push));
        end
        report_test("port_disable", errors_before);
    endtask

    // Simultaneous random reads and writes with occasional reconfiguration
    task automatic random_traffic();
        int errors_before;
        errors_before = error_count;
        repeat (200) begin
            next_rd_enable    = $urandom_range(0, 3) != 0;
            next_rd_addr      = pick_addr(io_port_pkg::RD_PORT_BASE_ADDR);
            next_rd_port_full = io_port_pkg::PORT_COUNT'($urandom);
            for (int i = 0; i < io_port_pkg::PORT_COUNT; i++) begin
                next_rd_port_data[i] = io_port_pkg::WORD_WIDTH'($urandom);
            end
            next_wr_enable    = $urandom_range(0, 3) != 0;
            next_wr_addr      = pick_addr(io_port_pkg::WR_PORT_BASE_ADDR);
            next_wr_data      = io_port_pkg::WORD_WIDTH'($urandom);
            next_wr_port_full = io_port_pkg::PORT_COUNT'($urandom);
            next_cfg_write    = $urandom_range(0, 15) == 0;
            next_cfg_data     = io_port_pkg::CFG_WIDTH'($urandom);
            step();
        end
        idle_inputs();
        step();
        report_test("random_traffic", errors_before);
    endtask

    // ----------------------------------------------------------
    // Run control
    // ----------------------------------------------------------

    initial begin
        #(2 * TEST_CYCLES * 10);
        $display("Watchdog expired after %0d ns with tests still running", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(59));
        {rd_enable, wr_enable, cfg_write} = '0;
        {rd_addr, wr_addr, wr_data, cfg_data} = '0;
        {rd_port_full, wr_port_full, rd_port_data} = '0;
        {next_rd_addr, next_wr_addr, next_wr_data, next_cfg_data} = '0;
        {next_rd_port_full, next_wr_port_full, next_rd_port_data} = '0;
        idle_inputs();
        rd_mask = '1;
        wr_mask = '1;
        {error_count, tests_passed, tests_failed} = '0;
        wait (reset == 1'b0);
        memory_access();
        full_port_reads();
        empty_port_read();
        port_writes();
        port_disable();
        random_traffic();
        $display("Tests passed %0d failed %0d", tests_passed, tests_failed);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: project.f
hw/io_port_pkg.sv
hw/io_check.sv
hw/io_read.sv
hw/io_write.sv
hw/io_port_config.sv
hw/io_subsystem.sv
sim/tb_clock.sv
sim/io_subsystem_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module io_subsystem_tb \
		-f project.f -o io_subsystem_sim
	./obj_dir/io_subsystem_sim | tee /dev/stderr | grep "Simulation passed" > /dev/null

clean:
	rm -rf obj_dir
